//--- logic/live_value_table.sv
`timescale 1ns/1ps

module live_value_table #(
  parameter int NUMADDR    = mpmem_pkg::DEF_NUMADDR,
  parameter int BITADDR    = $clog2(NUMADDR),
  parameter int NUMRDPT    = mpmem_pkg::DEF_NUMRDPT,
  parameter int NUMWRPT    = mpmem_pkg::DEF_NUMWRPT,
  parameter int BITWRPT    = $clog2(NUMWRPT),
  parameter int SRAM_DELAY = mpmem_pkg::DEF_SRAM_DELAY
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       sweep,
  input  logic [BITADDR-1:0]         sweep_addr,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_addr,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_addr,
  output logic [NUMRDPT*BITWRPT-1:0] rd_sel
);

  import mpmem_pkg::*;

  logic [BITWRPT-1:0] lvt_mem [NUMADDR]; // Last writer per address.

  logic [BITWRPT-1:0] sel_pipe [NUMRDPT][SRAM_DELAY];
  logic               vld_pipe [NUMRDPT][SRAM_DELAY];

  init_state_e sweep_state;

  ////////////////////
  // Table update
  ////////////////////

  // Ports are applied in order, the last assignment is the highest port.
  always_ff @(posedge clk) begin
    if (sweep) begin
      lvt_mem[sweep_addr] <= '0;
    end else begin
      for (int w = 0; w < NUMWRPT; w++) begin
        if (write[w]) begin
          lvt_mem[wr_addr[w*BITADDR +: BITADDR]] <= BITWRPT'(w);
        end
      end
    end
  end

  ////////////////////
  // Lookup pipeline
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUMRDPT; r++) begin
        for (int k = 0; k < SRAM_DELAY; k++) begin
          vld_pipe[r][k] <= 1'b0;
        end
      end
    end else begin
      for (int r = 0; r < NUMRDPT; r++) begin
        vld_pipe[r][0] <= read[r];
        for (int k = 1; k < SRAM_DELAY; k++) begin
          vld_pipe[r][k] <= vld_pipe[r][k-1];
        end
      end
    end
  end

  // Same hold behavior as the SRAM output so the select tracks its data.
  always_ff @(posedge clk) begin
    for (int r = 0; r < NUMRDPT; r++) begin
      if (read[r]) begin
        sel_pipe[r][0] <= lvt_mem[rd_addr[r*BITADDR +: BITADDR]]; // Pre-update value.
      end
      for (int k = 1; k < SRAM_DELAY; k++) begin
        if (vld_pipe[r][k-1]) begin
          sel_pipe[r][k] <= sel_pipe[r][k-1];
        end
      end
    end
  end

  for (genvar r = 0; r < NUMRDPT; r++) begin : g_sel
    assign rd_sel[r*BITWRPT +: BITWRPT] = sel_pipe[r][SRAM_DELAY-1];
  end

  assign sweep_state = sweep ? INIT_SWEEP : INIT_DONE;

  // The core must hold its ports quiet until the sweep has finished.
  ap_quiet_in_sweep: assert property (
    @(posedge clk) disable iff (!rst_n)
    (sweep_state == INIT_SWEEP) |-> (!(|write) && !(|read))
  );

endmodule

//--- logic/mpmem_core.sv
`timescale 1ns/1ps

module mpmem_core #(
  parameter int WIDTH      = mpmem_pkg::DEF_WIDTH,
  parameter int NUMADDR    = mpmem_pkg::DEF_NUMADDR,
  parameter int BITADDR    = $clog2(NUMADDR),
  parameter int NUMRDPT    = mpmem_pkg::DEF_NUMRDPT,
  parameter int NUMWRPT    = mpmem_pkg::DEF_NUMWRPT,
  parameter int BITWRPT    = $clog2(NUMWRPT),
  parameter int SRAM_DELAY = mpmem_pkg::DEF_SRAM_DELAY
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_addr,
  input  logic [NUMWRPT*WIDTH-1:0]   din,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_addr,
  output logic [NUMRDPT-1:0]         rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]   rd_dout,
  output logic                       ready
);

  import mpmem_pkg::*;

  localparam logic [BITADDR:0] SWEEP_LAST = (BITADDR+1)'(NUMADDR - 1);
  localparam logic [BITADDR:0] SWEEP_END  = (BITADDR+1)'(NUMADDR);

  init_state_e        init_state;
  logic [BITADDR:0]   init_cnt;
  logic               sweep;
  logic [BITADDR-1:0] sweep_addr;

  logic [NUMWRPT-1:0]         wr_acc;
  logic [NUMRDPT-1:0]         rd_acc;
  logic [NUMRDPT*BITWRPT-1:0] rd_sel;
  logic [SRAM_DELAY-1:0]      vld_sr [NUMRDPT];

  logic [WIDTH-1:0] copy_rdata [NUMWRPT][NUMRDPT];

  ////////////////////
  // Init sweep
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_state <= INIT_SWEEP;
      init_cnt   <= '0;
    end else if (init_state == INIT_SWEEP) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == SWEEP_LAST) begin
        init_state <= INIT_DONE;
      end
    end
  end

  assign sweep      = (init_state == INIT_SWEEP);
  assign sweep_addr = init_cnt[BITADDR-1:0];
  assign ready      = (init_state == INIT_DONE); // High the cycle after the last clear.

  assign wr_acc = write & {NUMWRPT{ready}};
  assign rd_acc = read & {NUMRDPT{ready}};

  ////////////////////
  // SRAM copies
  ////////////////////

  sram_port_if #(.BITADDR(BITADDR), .WIDTH(WIDTH)) sram_if [NUMWRPT*NUMRDPT] ();

  // Row w holds the writes of port w, column r serves read port r.
  for (genvar w = 0; w < NUMWRPT; w++) begin : g_row
    for (genvar r = 0; r < NUMRDPT; r++) begin : g_col
      localparam int IDX = w*NUMRDPT + r;

      assign sram_if[IDX].write = sweep | wr_acc[w];
      assign sram_if[IDX].waddr = sweep ? sweep_addr : wr_addr[w*BITADDR +: BITADDR];
      assign sram_if[IDX].wdata = sweep ? '0 : din[w*WIDTH +: WIDTH];
      assign sram_if[IDX].read  = rd_acc[r];
      assign sram_if[IDX].raddr = rd_addr[r*BITADDR +: BITADDR];
      assign copy_rdata[w][r]   = sram_if[IDX].rdata;

      sram_1r1w #(
        .WIDTH      (WIDTH),
        .NUMADDR    (NUMADDR),
        .BITADDR    (BITADDR),
        .SRAM_DELAY (SRAM_DELAY)
      ) i_sram (
        .clk  (clk),
        .port (sram_if[IDX])
      );
    end
  end

  live_value_table #(
    .NUMADDR    (NUMADDR),
    .BITADDR    (BITADDR),
    .NUMRDPT    (NUMRDPT),
    .NUMWRPT    (NUMWRPT),
    .BITWRPT    (BITWRPT),
    .SRAM_DELAY (SRAM_DELAY)
  ) i_lvt (
    .clk        (clk),
    .rst_n      (rst_n),
    .sweep      (sweep),
    .sweep_addr (sweep_addr),
    .write      (wr_acc),
    .wr_addr    (wr_addr),
    .read       (rd_acc),
    .rd_addr    (rd_addr),
    .rd_sel     (rd_sel)
  );

  ////////////////////
  // Read return
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUMRDPT; r++) begin
        vld_sr[r] <= '0;
      end
    end else begin
      for (int r = 0; r < NUMRDPT; r++) begin
        vld_sr[r][0] <= rd_acc[r];
        for (int k = 1; k < SRAM_DELAY; k++) begin
          vld_sr[r][k] <= vld_sr[r][k-1];
        end
      end
    end
  end

  always_comb begin
    rd_dout = '0;
    for (int r = 0; r < NUMRDPT; r++) begin
      rd_vld[r] = vld_sr[r][SRAM_DELAY-1];
      for (int w = 0; w < NUMWRPT; w++) begin
        if (rd_sel[r*BITWRPT +: BITWRPT] == BITWRPT'(w)) begin
          rd_dout[r*WIDTH +: WIDTH] = copy_rdata[w][r]; // Copy of the last writer.
        end
      end
    end
  end

  ap_vld_needs_ready: assert property (
    @(posedge clk) disable iff (!rst_n) !ready |-> !(|rd_vld)
  );

  ap_cnt_bound: assert property (
    @(posedge clk) disable iff (!rst_n) init_cnt <= SWEEP_END
  );

endmodule

//--- logic/mpmem_pkg.sv
package mpmem_pkg;

  ////////////////////
  // Default sizes
  ////////////////////

  parameter int DEF_WIDTH      = 32; // Data bits per word.
  parameter int DEF_NUMADDR    = 64; // Words per SRAM copy.
  parameter int DEF_NUMRDPT    = 2;  // Read ports.
  parameter int DEF_NUMWRPT    = 3;  // Write ports.
  parameter int DEF_SRAM_DELAY = 1;  // Read strobe to data.

  ////////////////////
  // Init sequencing
  ////////////////////

  // The core starts in the sweep after every reset and clears one address
  // per cycle in all copies and in the live value table.
  typedef enum logic {
    INIT_SWEEP = 1'b0, // Clearing memory, ports ignored.
    INIT_DONE  = 1'b1  // Memory usable.
  } init_state_e;

endpackage

//--- logic/mpmem_top_wrap.sv
`timescale 1ns/1ps

module mpmem_top_wrap #(
  parameter int WIDTH      = mpmem_pkg::DEF_WIDTH,
  parameter int NUMADDR    = mpmem_pkg::DEF_NUMADDR,
  parameter int NUMRDPT    = mpmem_pkg::DEF_NUMRDPT,
  parameter int NUMWRPT    = mpmem_pkg::DEF_NUMWRPT,
  parameter int SRAM_DELAY = mpmem_pkg::DEF_SRAM_DELAY,
  localparam int BITADDR   = $clog2(NUMADDR),
  localparam int BITWRPT   = $clog2(NUMWRPT)
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_addr,
  input  logic [NUMWRPT*WIDTH-1:0]   din,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_addr,
  output logic [NUMRDPT-1:0]         rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]   rd_dout,
  output logic                       ready
);

  logic [1:0] rst_sync;
  logic       rst_n;

  // Assert at once, release on the second edge after arst_n rises.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rst_n = rst_sync[1];

  mpmem_core #(
    .WIDTH      (WIDTH),
    .NUMADDR    (NUMADDR),
    .BITADDR    (BITADDR),
    .NUMRDPT    (NUMRDPT),
    .NUMWRPT    (NUMWRPT),
    .BITWRPT    (BITWRPT),
    .SRAM_DELAY (SRAM_DELAY)
  ) i_core (
    .clk     (clk),
    .rst_n   (rst_n),
    .write   (write),
    .wr_addr (wr_addr),
    .din     (din),
    .read    (read),
    .rd_addr (rd_addr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .ready   (ready)
  );

endmodule

//--- logic/sram_1r1w.sv
`timescale 1ns/1ps

module sram_1r1w #(
  parameter int WIDTH      = mpmem_pkg::DEF_WIDTH,
  parameter int NUMADDR    = mpmem_pkg::DEF_NUMADDR,
  parameter int BITADDR    = $clog2(NUMADDR),
  parameter int SRAM_DELAY = mpmem_pkg::DEF_SRAM_DELAY
) (
  input logic       clk,
  sram_port_if.mem  port
);

  logic [WIDTH-1:0] mem [NUMADDR];

  logic [WIDTH-1:0] dout_pipe [SRAM_DELAY];
  logic             vld_pipe  [SRAM_DELAY];

  ////////////////////
  // Array
  ////////////////////

  // Read and write share one edge, so a colliding read sees the old word.
  always_ff @(posedge clk) begin
    if (port.write) begin
      mem[port.waddr] <= port.wdata;
    end
  end

  ////////////////////
  // Read pipeline
  ////////////////////

  // A stage only moves when it carries a read, so rdata holds between reads.
  always_ff @(posedge clk) begin
    if (port.read) begin
      dout_pipe[0] <= mem[port.raddr];
    end
    vld_pipe[0] <= port.read;
    for (int k = 1; k < SRAM_DELAY; k++) begin
      vld_pipe[k] <= vld_pipe[k-1];
      if (vld_pipe[k-1]) begin
        dout_pipe[k] <= dout_pipe[k-1];
      end
    end
  end

  assign port.rdata = dout_pipe[SRAM_DELAY-1];

  ap_waddr_range: assert property (
    @(posedge clk) port.write |-> ({1'b0, port.waddr} < (BITADDR+1)'(NUMADDR))
  );

  ap_raddr_range: assert property (
    @(posedge clk) port.read |-> ({1'b0, port.raddr} < (BITADDR+1)'(NUMADDR))
  );

endmodule

//--- logic/sram_port_if.sv
`timescale 1ns/1ps

interface sram_port_if #(
  parameter int BITADDR = 6,
  parameter int WIDTH   = 32
) ();

  logic               write;
  logic [BITADDR-1:0] waddr;
  logic [WIDTH-1:0]   wdata;
  logic               read;
  logic [BITADDR-1:0] raddr;
  logic [WIDTH-1:0]   rdata; // Valid SRAM_DELAY cycles after read.

  modport ctrl (
    output write,
    output waddr,
    output wdata,
    output read,
    output raddr,
    input  rdata
  );

  modport mem (
    input  write,
    input  waddr,
    input  wdata,
    input  read,
    input  raddr,
    output rdata
  );

endinterface

//--- mpmem_top_wrap.f
logic/mpmem_pkg.sv
logic/sram_port_if.sv
logic/sram_1r1w.sv
logic/live_value_table.sv
logic/mpmem_core.sv
logic/mpmem_top_wrap.sv
verification/clk_rst_gen.sv
verification/mpmem_checker.sv
verification/tb_mpmem.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mpmem \
  -f mpmem_top_wrap.f -Mdir obj_dir -o sim_mpmem \
  && ./obj_dir/sim_mpmem | tee /dev/stderr | grep -F "Done: no errors" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- verification/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS/2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1; // Released on a rising edge.
  end

endmodule

//--- verification/mpmem_checker.sv
`timescale 1ns/1ps

module mpmem_checker #(
  parameter int WIDTH      = mpmem_pkg::DEF_WIDTH,
  parameter int NUMADDR    = mpmem_pkg::DEF_NUMADDR,
  parameter int NUMRDPT    = mpmem_pkg::DEF_NUMRDPT,
  parameter int NUMWRPT    = mpmem_pkg::DEF_NUMWRPT,
  parameter int SRAM_DELAY = mpmem_pkg::DEF_SRAM_DELAY,
  localparam int BITADDR   = $clog2(NUMADDR)
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_addr,
  input  logic [NUMWRPT*WIDTH-1:0]   din,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_addr,
  input  logic [NUMRDPT-1:0]         rd_vld,
  input  logic [NUMRDPT*WIDTH-1:0]   rd_dout,
  input  logic                       ready,
  output int                         err_cnt,
  output int                         chk_cnt,
  output int                         pending
);

  logic [WIDTH-1:0] model [NUMADDR];
  logic [WIDTH-1:0] exp_q [NUMRDPT][$]; // Expected word per read in flight.
  int               due_q [NUMRDPT][$]; // Sample cycle at which rd_vld is owed.
  int               cyc;
  int               rdy_cnt; // Samples since the reset release.

  initial begin
    err_cnt = 0;
    chk_cnt = 0;
    pending = 0;
    cyc     = 0;
    rdy_cnt = 0;
    for (int a = 0; a < NUMADDR; a++) begin
      model[a] = '0;
    end
  end

  // Everything is sampled at the rising edge, so it reflects the cycle just ended.
  always @(posedge clk) begin
    logic [WIDTH-1:0] exp_word;
    logic [WIDTH-1:0] got_word;
    int               due;
    logic             exp_ready;
    cyc = cyc + 1;
    if (!arst_n) begin
      rdy_cnt = 0;
      if ((|rd_vld) === 1'b1) begin
        $display("rd_vld is high while reset is asserted");
        err_cnt++;
      end
      for (int a = 0; a < NUMADDR; a++) begin
        model[a] = '0; // Memory is swept again after reset.
      end
      for (int r = 0; r < NUMRDPT; r++) begin
        exp_q[r].delete();
        due_q[r].delete();
      end
    end else begin
      rdy_cnt   = rdy_cnt + 1;
      exp_ready = (rdy_cnt > NUMADDR + 2); // Two sync edges and one clear per address.
      if (ready !== exp_ready) begin
        $display("ERROR ready expected 0x%h actual 0x%h", exp_ready, ready);
        err_cnt++;
      end
      ////////////////////
      // Read returns
      ////////////////////
      for (int r = 0; r < NUMRDPT; r++) begin
        if (rd_vld[r]) begin
          if (exp_q[r].size() == 0) begin
            $display("Read port %0d returned data with no read pending", r);
            err_cnt++;
          end else begin
            exp_word = exp_q[r].pop_front();
            due      = due_q[r].pop_front();
            got_word = rd_dout[r*WIDTH +: WIDTH];
            chk_cnt++;
            if (due != cyc) begin
              $display("Read port %0d returned at cycle %0d instead of %0d", r, cyc, due);
              err_cnt++;
            end
            if (got_word !== exp_word) begin
              $display("ERROR rd_dout[%0d] expected 0x%h actual 0x%h", r, exp_word, got_word);
              err_cnt++;
            end
          end
        end else if (due_q[r].size() != 0 && due_q[r][0] <= cyc) begin
          $display("Read port %0d left a read unanswered", r);
          err_cnt++;
          void'(exp_q[r].pop_front());
          void'(due_q[r].pop_front());
        end
      end
      if (!ready && (|rd_vld) === 1'b1) begin
        $display("rd_vld is high while ready is low");
        err_cnt++;
      end
      ////////////////////
      // Accepted ports
      ////////////////////
      if (exp_ready) begin
        for (int r = 0; r < NUMRDPT; r++) begin
          if (read[r]) begin
            exp_q[r].push_back(model[rd_addr[r*BITADDR +: BITADDR]]); // Old word.
            due_q[r].push_back(cyc + SRAM_DELAY);
          end
        end
        for (int w = 0; w < NUMWRPT; w++) begin
          if (write[w]) begin
            model[wr_addr[w*BITADDR +: BITADDR]] = din[w*WIDTH +: WIDTH]; // Highest port last.
          end
        end
      end
    end
    pending = 0;
    for (int r = 0; r < NUMRDPT; r++) begin
      pending += exp_q[r].size();
    end
  end

endmodule

//--- verification/tb_mpmem.sv
`timescale 1ns/1ps

module tb_mpmem;

  import mpmem_pkg::*;

  localparam int WIDTH      = DEF_WIDTH;
  localparam int NUMADDR    = DEF_NUMADDR;
  localparam int NUMRDPT    = DEF_NUMRDPT;
  localparam int NUMWRPT    = DEF_NUMWRPT;
  localparam int SRAM_DELAY = DEF_SRAM_DELAY;
  localparam int BITADDR    = $clog2(NUMADDR);

  // Test lengths in cycles.
  localparam int LEN_INIT    = 32;
  localparam int LEN_RAND    = 2000;
  localparam int LEN_COLL    = 64;
  localparam int LEN_RDW     = 64;
  localparam int LEN_PIPE    = 32;
  localparam int LEN_RESET   = 106 + NUMADDR/2 + NUMADDR/NUMRDPT;
  localparam int LEN_SUM     = LEN_INIT + LEN_RAND + LEN_COLL + LEN_RDW + LEN_PIPE + LEN_RESET;
  localparam int CYCLE_LIMIT = 2*LEN_SUM + 2*NUMADDR;

  logic                       clk;
  logic                       gen_rst_n;
  logic                       tb_rst_n;
  logic                       arst_n;
  logic [NUMWRPT-1:0]         write;
  logic [NUMWRPT*BITADDR-1:0] wr_addr;
  logic [NUMWRPT*WIDTH-1:0]   din;
  logic [NUMRDPT-1:0]         read;
  logic [NUMRDPT*BITADDR-1:0] rd_addr;
  logic [NUMRDPT-1:0]         rd_vld;
  logic [NUMRDPT*WIDTH-1:0]   rd_dout;
  logic                       ready;

  int          err_cnt;
  int          chk_cnt;
  int          pending;
  int          tb_errs;
  int          errs0;
  int          chks0;
  int          cycle = 0;
  logic [31:0] rng_state;

  assign arst_n = gen_rst_n & tb_rst_n; // Power-on reset plus mid-run reset.

  clk_rst_gen #(.PERIOD_NS(100), .RST_CYCLES(5)) i_clk_rst (.clk(clk), .arst_n(gen_rst_n));

  mpmem_top_wrap #(
    .WIDTH(WIDTH), .NUMADDR(NUMADDR), .NUMRDPT(NUMRDPT),
    .NUMWRPT(NUMWRPT), .SRAM_DELAY(SRAM_DELAY)
  ) i_mpmem_top_wrap (
    .clk(clk), .arst_n(arst_n), .write(write), .wr_addr(wr_addr), .din(din),
    .read(read), .rd_addr(rd_addr), .rd_vld(rd_vld), .rd_dout(rd_dout), .ready(ready)
  );

  mpmem_checker #(
    .WIDTH(WIDTH), .NUMADDR(NUMADDR), .NUMRDPT(NUMRDPT),
    .NUMWRPT(NUMWRPT), .SRAM_DELAY(SRAM_DELAY)
  ) i_checker (
    .clk(clk), .arst_n(arst_n), .write(write), .wr_addr(wr_addr), .din(din),
    .read(read), .rd_addr(rd_addr), .rd_vld(rd_vld), .rd_dout(rd_dout), .ready(ready),
    .err_cnt(err_cnt), .chk_cnt(chk_cnt), .pending(pending)
  );

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [BITADDR-1:0] rand_addr();
    logic [31:0] rv;
    rv = rand_word();
    return BITADDR'(rv % NUMADDR);
  endfunction

  task automatic drive_idle();
    @(posedge clk);
    write <= '0;
    read  <= '0;
  endtask

  task automatic drive_random();
    logic [31:0] bits;
    @(posedge clk);
    bits = rand_word();
    for (int w = 0; w < NUMWRPT; w++) begin
      write[w]                      <= bits[w];
      wr_addr[w*BITADDR +: BITADDR] <= rand_addr();
      din[w*WIDTH +: WIDTH]         <= WIDTH'(rand_word());
    end
    for (int r = 0; r < NUMRDPT; r++) begin
      read[r]                       <= bits[8+r];
      rd_addr[r*BITADDR +: BITADDR] <= rand_addr();
    end
  endtask

  task automatic read_cycle();
    @(posedge clk);
    write <= '0;
    read  <= '1;
    for (int r = 0; r < NUMRDPT; r++) begin
      rd_addr[r*BITADDR +: BITADDR] <= rand_addr();
    end
  endtask

  // All write ports hit one address, then every read port reads it back.
  task automatic collide_round();
    logic [BITADDR-1:0] a;
    a = rand_addr();
    @(posedge clk);
    write <= '1;
    read  <= '0;
    for (int w = 0; w < NUMWRPT; w++) begin
      wr_addr[w*BITADDR +: BITADDR] <= a;
      din[w*WIDTH +: WIDTH]         <= WIDTH'(rand_word());
    end
    @(posedge clk);
    write <= '0;
    read  <= '1;
    for (int r = 0; r < NUMRDPT; r++) begin
      rd_addr[r*BITADDR +: BITADDR] <= a;
    end
  endtask

  task automatic rdw_round();
    logic [BITADDR-1:0] a;
    int                 w;
    a = rand_addr();
    w = int'(rand_word() % NUMWRPT);
    @(posedge clk);
    write                         <= NUMWRPT'(1) << w;
    wr_addr[w*BITADDR +: BITADDR] <= a;
    din[w*WIDTH +: WIDTH]         <= WIDTH'(rand_word());
    read                          <= '1;
    for (int r = 0; r < NUMRDPT; r++) begin
      rd_addr[r*BITADDR +: BITADDR] <= a;
    end
    @(posedge clk);
    write <= '0; // Same reads again, now after the write.
  endtask

  task automatic wait_ready();
    do @(negedge clk); while (ready !== 1'b1);
  endtask

  task automatic report_test(input string name);
    drive_idle();
    do @(negedge clk); while (pending != 0);
    $display("Test %-18s checks %5d  errors %0d", name, chk_cnt - chks0,
             err_cnt + tb_errs - errs0);
    errs0 = err_cnt + tb_errs;
    chks0 = chk_cnt;
  endtask

  task automatic reset_during_traffic();
    repeat (100) drive_random();
    @(posedge clk);
    tb_rst_n <= 1'b0;
    repeat (3) drive_random();
    @(negedge clk);
    if (ready !== 1'b0) begin
      $display("ERROR ready expected 0x0 actual 0x%h", ready);
      tb_errs++;
    end
    if (rd_vld !== '0) begin
      $display("ERROR rd_vld expected 0x0 actual 0x%h", rd_vld);
      tb_errs++;
    end
    @(posedge clk);
    tb_rst_n <= 1'b1;
    repeat (NUMADDR/2) drive_random(); // Ignored while the sweep runs.
    drive_idle();
    wait_ready();
    for (int a = 0; a < NUMADDR; a += NUMRDPT) begin
      @(posedge clk);
      read <= '1;
      for (int r = 0; r < NUMRDPT; r++) begin
        rd_addr[r*BITADDR +: BITADDR] <= BITADDR'(a + r);
      end
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    rng_state = 32'ha59a;
    tb_rst_n  = 1'b1;
    write     = '0;
    wr_addr   = '0;
    din       = '0;
    read      = '0;
    rd_addr   = '0;
    tb_errs   = 0;
    errs0     = 0;
    chks0     = 0;
    wait_ready();
    repeat (LEN_INIT) read_cycle();
    report_test("init");
    repeat (LEN_RAND) drive_random();
    report_test("random_traffic");
    repeat (LEN_COLL/2) collide_round();
    report_test("collision");
    repeat (LEN_RDW/2) rdw_round();
    report_test("read_during_write");
    repeat (LEN_PIPE) read_cycle();
    report_test("pipeline");
    reset_during_traffic();
    report_test("midrun_reset");
    $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt + tb_errs);
    if (err_cnt + tb_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule
